/* apb1_ctrl/apb1_state_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module apb1_state_ctrl import apb1_pkg::*; (
  input  wire        i_hclk,
  input  wire        i_rst_n,
  input  wire        i_pclk_en,
  input  wire        i_hsel,
  input  wire        i_hreadyin,
  input  wire  [1:0] i_htrans,
  input  wire        i_dec_hit,
  input  wire        i_pready,
  input  wire        i_pslverr,
  output logic       o_hreadyout,
  output logic [1:0] o_hresp,
  output logic       o_req_load,
  output logic       o_wdata_load,
  output logic       o_psel_en,
  output logic       o_penable,
  output logic       o_rdata_load
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_PCLK,
    ST_SETUP,
    ST_ACCESS,
    ST_ERR1,
    ST_ERR2
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   trans_valid;
  logic   accept;
  logic   wdata_load_q;

  // Only NONSEQ and SEQ start an APB transfer.
  always_comb begin
    case (i_htrans)
      HTRANS_NONSEQ, HTRANS_SEQ: trans_valid = 1'b1;
      HTRANS_IDLE, HTRANS_BUSY:  trans_valid = 1'b0;
      default:                   trans_valid = 1'b0;
    endcase
  end

  assign accept = i_hsel & i_hreadyin & o_hreadyout & trans_valid;

  // ~~~~~~~~~~~~~~~~~~~~
  // AHB response.
  // ~~~~~~~~~~~~~~~~~~~~
  assign o_hreadyout = (state_q == ST_IDLE) || (state_q == ST_ERR2);
  assign o_hresp     = ((state_q == ST_ERR1) || (state_q == ST_ERR2)) ? HRESP_ERROR
                                                                      : HRESP_OKAY;

  // ~~~~~~~~~~~~~~~~~~~~
  // APB phase controls.
  // ~~~~~~~~~~~~~~~~~~~~
  assign o_req_load   = accept;
  assign o_wdata_load = wdata_load_q;
  assign o_psel_en    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
  assign o_penable    = (state_q == ST_ACCESS);
  assign o_rdata_load = (state_q == ST_ACCESS) & i_pclk_en & i_pready & ~i_pslverr;

  always_comb begin
    state_d = state_q;
    case (state_q)
      // ERR2 already shows hreadyout high, so the next transfer may start there.
      ST_IDLE, ST_ERR2: begin
        if (accept) begin
          state_d = ST_WAIT_PCLK;
        end else begin
          state_d = ST_IDLE;
        end
      end
      ST_WAIT_PCLK: begin
        if (i_pclk_en) begin
          if (i_dec_hit) begin
            state_d = ST_SETUP;
          end else begin
            state_d = ST_ERR1;
          end
        end
      end
      ST_SETUP: begin
        if (i_pclk_en) begin
          state_d = ST_ACCESS;
        end
      end
      ST_ACCESS: begin
        if (i_pclk_en && i_pready) begin
          if (i_pslverr) begin
            state_d = ST_ERR1;
          end else begin
            state_d = ST_IDLE;
          end
        end
      end
      ST_ERR1: begin
        state_d = ST_ERR2;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_hclk) begin
    if (!i_rst_n) begin
      state_q      <= ST_IDLE;
      wdata_load_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      // Write data follows the address phase by one cycle.
      wdata_load_q <= accept;
    end
  end

endmodule

`default_nettype wire

/* common/apb1_pkg.sv */
`default_nettype none

package apb1_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Bus widths.
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // One strobe bit per byte lane.
  localparam int STRB_W = DATA_W / 8;
  localparam int PROT_W = 3;

  // ~~~~~~~~~~~~~~~~~~~~
  // AHB transfer types.
  // ~~~~~~~~~~~~~~~~~~~~
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // AHB responses.
  localparam logic [1:0] HRESP_OKAY  = 2'b00;
  localparam logic [1:0] HRESP_ERROR = 2'b01;

  // ~~~~~~~~~~~~~~~~~~~~
  // AHB transfer sizes.
  // ~~~~~~~~~~~~~~~~~~~~
  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

endpackage

`default_nettype wire

/* filelist.f */
common/apb1_pkg.sv
apb1_ctrl/apb1_state_ctrl.sv
src/apb1_req_hold.sv
src/apb1_addr_decode.sv
src/apb1_resp_mux.sv
src/apb1_top.sv
verif/apb1_clk_gen.sv
verif/apb1_chk.sv
verif/apb1_tb.sv

/* src/apb1_addr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module apb1_addr_decode import apb1_pkg::*; #(
  parameter int SLV_NUM      = 16,
  parameter int SLV_ADDR_LSB = 12
) (
  input  wire  [ADDR_W-1:0]  i_paddr,
  input  wire                i_psel_en,
  output logic [3:0]         o_slv_idx,
  output logic               o_dec_hit,
  output logic [SLV_NUM-1:0] o_psel
);

  // ~~~~~~~~~~~~~~~~~~~~
  // Slave window index.
  // ~~~~~~~~~~~~~~~~~~~~
  assign o_slv_idx = i_paddr[SLV_ADDR_LSB +: 4];

  // Indices at or above SLV_NUM are unmapped.
  assign o_dec_hit = int'(o_slv_idx) < SLV_NUM;

  // One-hot select, only during SETUP and ACCESS.
  always_comb begin
    o_psel = '0;
    for (int i = 0; i < SLV_NUM; i++) begin
      if (int'(o_slv_idx) == i) begin
        o_psel[i] = i_psel_en;
      end
    end
  end

endmodule

`default_nettype wire

/* src/apb1_req_hold.sv */
`timescale 1ns/1ns
`default_nettype none

module apb1_req_hold import apb1_pkg::*; (
  input  wire               i_hclk,
  input  wire               i_rst_n,
  input  wire               i_req_load,
  input  wire               i_wdata_load,
  input  wire  [ADDR_W-1:0] i_haddr,
  input  wire               i_hwrite,
  input  wire  [2:0]        i_hsize,
  input  wire  [3:0]        i_hprot,
  input  wire  [DATA_W-1:0] i_hwdata,
  output logic [ADDR_W-1:0] o_paddr,
  output logic              o_pwrite,
  output logic [DATA_W-1:0] o_pwdata,
  output logic [STRB_W-1:0] o_pstrb,
  output logic [PROT_W-1:0] o_pprot
);

  localparam int LANE_W = $clog2(STRB_W);

  logic [LANE_W-1:0] lane;
  logic [STRB_W-1:0] strb_d;

  assign lane = i_haddr[LANE_W-1:0];

  // Byte lanes from size and low address bits.
  always_comb begin
    if (!i_hwrite) begin
      strb_d = '0;
    end else begin
      case (i_hsize)
        HSIZE_BYTE: strb_d = STRB_W'(1) << lane;
        HSIZE_HALF: strb_d = STRB_W'(3) << {lane[LANE_W-1:1], 1'b0};
        HSIZE_WORD: strb_d = '1;
        default:    strb_d = '1;
      endcase
    end
  end

  always_ff @(posedge i_hclk) begin
    if (!i_rst_n) begin
      o_pwrite <= 1'b0;
      o_pstrb  <= '0;
      o_pprot  <= '0;
    end else if (i_req_load) begin
      o_pwrite <= i_hwrite;
      o_pstrb  <= strb_d;
      // Data/instruction, non-secure, privileged.
      o_pprot  <= {~i_hprot[0], 1'b1, i_hprot[1]};
    end
  end

  always_ff @(posedge i_hclk) begin
    if (i_req_load) begin
      o_paddr <= i_haddr;
    end
    if (i_wdata_load) begin
      o_pwdata <= i_hwdata;
    end
  end

endmodule

`default_nettype wire

/* src/apb1_resp_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module apb1_resp_mux import apb1_pkg::*; #(
  parameter int SLV_NUM = 16
) (
  input  wire                              i_hclk,
  input  wire                              i_rst_n,
  input  wire  [3:0]                       i_slv_idx,
  input  wire                              i_rdata_load,
  input  wire  [SLV_NUM-1:0]               i_pready,
  input  wire  [SLV_NUM-1:0]               i_pslverr,
  input  wire  [SLV_NUM-1:0][DATA_W-1:0]   i_prdata,
  output logic                             o_pready,
  output logic                             o_pslverr,
  output logic [DATA_W-1:0]                o_hrdata
);

  logic [DATA_W-1:0] sel_rdata;

  // Unmapped indices select nothing.
  always_comb begin
    o_pready  = 1'b0;
    o_pslverr = 1'b0;
    sel_rdata = '0;
    for (int i = 0; i < SLV_NUM; i++) begin
      if (int'(i_slv_idx) == i) begin
        o_pready  = i_pready[i];
        o_pslverr = i_pslverr[i];
        sel_rdata = i_prdata[i];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Read data capture.
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge i_hclk) begin
    if (!i_rst_n) begin
      o_hrdata <= '0;
    end else if (i_rdata_load) begin
      o_hrdata <= sel_rdata;
    end
  end

endmodule

`default_nettype wire

/* src/apb1_top.sv */
`timescale 1ns/1ns
`default_nettype none

module apb1_top import apb1_pkg::*; #(
  parameter int SLV_NUM      = 16,
  parameter int SLV_ADDR_LSB = 12
) (
  input  wire                            i_hclk,
  input  wire                            i_rst_n,
  input  wire                            i_pclk_en,
  // AHB slave port.
  input  wire                            i_hsel,
  input  wire                            i_hreadyin,
  input  wire  [ADDR_W-1:0]              i_haddr,
  input  wire                            i_hwrite,
  input  wire  [1:0]                     i_htrans,
  input  wire  [2:0]                     i_hsize,
  input  wire  [3:0]                     i_hprot,
  input  wire  [DATA_W-1:0]              i_hwdata,
  output logic                           o_hreadyout,
  output logic [1:0]                     o_hresp,
  output logic [DATA_W-1:0]              o_hrdata,
  // Shared APB bus.
  output logic [ADDR_W-1:0]              o_paddr,
  output logic                           o_pwrite,
  output logic [DATA_W-1:0]              o_pwdata,
  output logic [STRB_W-1:0]              o_pstrb,
  output logic [PROT_W-1:0]              o_pprot,
  output logic                           o_penable,
  // Per-slave lines.
  output logic [SLV_NUM-1:0]             o_psel,
  input  wire  [SLV_NUM-1:0]             i_pready,
  input  wire  [SLV_NUM-1:0]             i_pslverr,
  input  wire  [SLV_NUM-1:0][DATA_W-1:0] i_prdata
);

  logic       req_load;
  logic       wdata_load;
  logic       psel_en;
  logic       rdata_load;
  logic       dec_hit;
  logic [3:0] slv_idx;
  logic       mux_pready;
  logic       mux_pslverr;

  // ~~~~~~~~~~~~~~~~~~~~
  // Control.
  // ~~~~~~~~~~~~~~~~~~~~
  apb1_state_ctrl apb1_state_ctrl_i (
    .i_hclk       (i_hclk),
    .i_rst_n      (i_rst_n),
    .i_pclk_en    (i_pclk_en),
    .i_hsel       (i_hsel),
    .i_hreadyin   (i_hreadyin),
    .i_htrans     (i_htrans),
    .i_dec_hit    (dec_hit),
    .i_pready     (mux_pready),
    .i_pslverr    (mux_pslverr),
    .o_hreadyout  (o_hreadyout),
    .o_hresp      (o_hresp),
    .o_req_load   (req_load),
    .o_wdata_load (wdata_load),
    .o_psel_en    (psel_en),
    .o_penable    (o_penable),
    .o_rdata_load (rdata_load)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // Datapath.
  // ~~~~~~~~~~~~~~~~~~~~
  apb1_req_hold apb1_req_hold_i (
    .i_hclk       (i_hclk),
    .i_rst_n      (i_rst_n),
    .i_req_load   (req_load),
    .i_wdata_load (wdata_load),
    .i_haddr      (i_haddr),
    .i_hwrite     (i_hwrite),
    .i_hsize      (i_hsize),
    .i_hprot      (i_hprot),
    .i_hwdata     (i_hwdata),
    .o_paddr      (o_paddr),
    .o_pwrite     (o_pwrite),
    .o_pwdata     (o_pwdata),
    .o_pstrb      (o_pstrb),
    .o_pprot      (o_pprot)
  );

  apb1_addr_decode #(
    .SLV_NUM      (SLV_NUM),
    .SLV_ADDR_LSB (SLV_ADDR_LSB)
  ) apb1_addr_decode_i (
    .i_paddr      (o_paddr),
    .i_psel_en    (psel_en),
    .o_slv_idx    (slv_idx),
    .o_dec_hit    (dec_hit),
    .o_psel       (o_psel)
  );

  apb1_resp_mux #(
    .SLV_NUM      (SLV_NUM)
  ) apb1_resp_mux_i (
    .i_hclk       (i_hclk),
    .i_rst_n      (i_rst_n),
    .i_slv_idx    (slv_idx),
    .i_rdata_load (rdata_load),
    .i_pready     (i_pready),
    .i_pslverr    (i_pslverr),
    .i_prdata     (i_prdata),
    .o_pready     (mux_pready),
    .o_pslverr    (mux_pslverr),
    .o_hrdata     (o_hrdata)
  );

endmodule

`default_nettype wire

/* verif/apb1_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module apb1_chk import apb1_pkg::*; #(
  parameter int SLV_NUM = 16
) (
  input wire                                   i_hclk,
  input wire                                   i_rst_n,
  input wire                                   i_pclk_en,
  input wire                                   i_accept,
  input wire [3:0]                             i_hprot,
  input wire                                   i_hreadyout,
  input wire [1:0]                             i_hresp,
  input wire [SLV_NUM-1:0]                     i_psel,
  input wire                                   i_penable,
  input wire [SLV_NUM-1:0]                     i_pready,
  input wire [PROT_W-1:0]                      i_pprot,
  input wire [ADDR_W+DATA_W+STRB_W+PROT_W:0]   i_apb_bus
);

  int   err_cnt = 0;
  logic sel_ready;

  assign sel_ready = |(i_psel & i_pready);

  // ~~~~~~~~~~~~~~~~~~~~
  // Reset and AHB side.
  // ~~~~~~~~~~~~~~~~~~~~
  reset_idle: assert property (@(posedge i_hclk)
    !i_rst_n |=> i_hreadyout && i_hresp == HRESP_OKAY && i_psel == '0 && !i_penable)
    else begin
      err_cnt++;
      $error("bus not idle after reset");
    end

  err_two_cycle: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
    i_hresp == HRESP_ERROR && !i_hreadyout |=> i_hresp == HRESP_ERROR && i_hreadyout)
    else begin
      err_cnt++;
      $error("error response not followed by its second cycle");
    end

  // Privileged follows hprot[1], always non-secure, instruction when hprot[0] is low.
  prot_map: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
    i_accept |=> i_pprot[0] == $past(i_hprot[1]) && i_pprot[1] == 1'b1 &&
                 i_pprot[2] == !$past(i_hprot[0]))
    else begin
      err_cnt++;
      $error("pprot does not follow hprot");
    end

  // ~~~~~~~~~~~~~~~~~~~~
  // APB side.
  // ~~~~~~~~~~~~~~~~~~~~
  sel_onehot: assert property (@(posedge i_hclk) disable iff (!i_rst_n) $onehot0(i_psel))
    else begin
      err_cnt++;
      $error("more than one psel high");
    end

  setup_first: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
    $rose(|i_psel) |-> !i_penable)
    else begin
      err_cnt++;
      $error("psel rose together with penable");
    end

  penable_after_setup: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
    $rose(i_penable) |-> $past(|i_psel) && !$past(i_penable) && $past(i_pclk_en))
    else begin
      err_cnt++;
      $error("penable rose without a pclk-enabled setup edge");
    end

  // Every APB output is held until the slave completes.
  access_stable: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
    i_penable && !(i_pclk_en && sel_ready) |=> i_penable && $stable(i_psel) && $stable(i_apb_bus))
    else begin
      err_cnt++;
      $error("APB outputs changed during a wait state");
    end

endmodule

bind apb1_top apb1_chk #(.SLV_NUM(SLV_NUM)) apb1_chk_i (
  .i_hclk      (i_hclk),
  .i_rst_n     (i_rst_n),
  .i_pclk_en   (i_pclk_en),
  .i_accept    (i_hsel && i_hreadyin && o_hreadyout &&
                (i_htrans == HTRANS_NONSEQ || i_htrans == HTRANS_SEQ)),
  .i_hprot     (i_hprot),
  .i_hreadyout (o_hreadyout),
  .i_hresp     (o_hresp),
  .i_psel      (o_psel),
  .i_penable   (o_penable),
  .i_pready    (i_pready),
  .i_pprot     (o_pprot),
  .i_apb_bus   ({o_paddr, o_pwrite, o_pwdata, o_pstrb, o_pprot})
);

`default_nettype wire

/* verif/apb1_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module apb1_clk_gen #(
  parameter int HALF_PERIOD = 20,
  parameter int RST_CYCLES  = 8
) (
  output logic o_hclk,
  output logic o_rst_n
);

  initial begin
    o_hclk = 1'b0;
    forever #HALF_PERIOD o_hclk = ~o_hclk;
  end

  // Reset held low for a fixed number of rising edges.
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_hclk);
    o_rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* verif/apb1_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module apb1_tb import apb1_pkg::*; ();

  localparam int SLV_NUM = 12;
  localparam int WORDS   = 1024;
  localparam int TIMEOUT = 200;

  logic                           i_hclk;
  logic                           i_rst_n;
  logic                           i_pclk_en = 1'b0;
  logic                           i_hsel;
  logic                           i_hreadyin;
  logic [ADDR_W-1:0]              i_haddr;
  logic                           i_hwrite;
  logic [1:0]                     i_htrans;
  logic [2:0]                     i_hsize;
  logic [3:0]                     i_hprot;
  logic [DATA_W-1:0]              i_hwdata;
  logic                           o_hreadyout;
  logic [1:0]                     o_hresp;
  logic [DATA_W-1:0]              o_hrdata;
  logic [ADDR_W-1:0]              o_paddr;
  logic                           o_pwrite;
  logic [DATA_W-1:0]              o_pwdata;
  logic [STRB_W-1:0]              o_pstrb;
  logic [PROT_W-1:0]              o_pprot;
  logic                           o_penable;
  logic [SLV_NUM-1:0]             o_psel;
  logic [SLV_NUM-1:0]             i_pready = '0;
  logic [SLV_NUM-1:0]             i_pslverr = '0;
  logic [SLV_NUM-1:0][DATA_W-1:0] i_prdata = '0;

  logic [DATA_W-1:0] slave_mem [SLV_NUM][WORDS];
  logic [DATA_W-1:0] ref_mem [SLV_NUM][WORDS];
  int                pclk_low = 0;
  int                errors = 0;
  int                n_pass = 0;
  int                n_fail = 0;
  int                base_errors;
  int                base_chk;
  logic              timed_out = 1'b0;

  apb1_clk_gen apb1_clk_gen_i (.o_hclk(i_hclk), .o_rst_n(i_rst_n));

  apb1_top #(.SLV_NUM(SLV_NUM), .SLV_ADDR_LSB(12)) apb1_top_i (.*);

  function automatic logic [DATA_W-1:0] fill_word(input int slv, input int word);
    logic [ADDR_W-1:0] addr;
    addr = (ADDR_W'(slv) << 12) | (ADDR_W'(word) << 2);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
  endfunction

  // Lanes written by an AHB transfer of the given size at the given byte offset.
  function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old_word,
      input logic [DATA_W-1:0] wdata, input logic [2:0] size, input logic [1:0] lo);
    logic [DATA_W-1:0] res;
    logic              hit;
    res = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      case (size)
        HSIZE_BYTE: hit = (b == lo);
        HSIZE_HALF: hit = (b / 2 == lo[1]);
        default:    hit = 1'b1;
      endcase
      if (hit) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // APB slave models.
  // ~~~~~~~~~~~~~~~~~~~~
  always @(posedge i_hclk) begin
    int word;
    word = int'(o_paddr[11:2]);
    for (int s = 0; s < SLV_NUM; s++) begin
      i_pready[s]  <= ($urandom % 3) != 0;
      i_pslverr[s] <= (o_paddr[11:0] == 12'hffc);
      if (!i_rst_n) begin
        for (int w = 0; w < WORDS; w++) begin
          slave_mem[s][w] = fill_word(s, w);
        end
      end else if (o_psel[s] && o_penable && i_pclk_en && i_pready[s] && !i_pslverr[s] &&
                   o_pwrite) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (o_pstrb[b]) begin
            slave_mem[s][word][8*b +: 8] = o_pwdata[8*b +: 8];
          end
        end
      end
      i_prdata[s] <= slave_mem[s][word];
    end
  end

  // Never more than two low cycles in a row.
  always @(posedge i_hclk) begin
    if (pclk_low >= 2 || ($urandom % 2) == 1) begin
      i_pclk_en <= 1'b1;
      pclk_low  <= 0;
    end else begin
      i_pclk_en <= 1'b0;
      pclk_low  <= pclk_low + 1;
    end
  end

  task automatic log_error(input string msg);
    errors++;
    $display("error %0t: %s", $time, msg);
  endtask

  // resp is {error seen with hreadyout low, error on the final cycle}.
  task automatic ahb_xfer(input logic [ADDR_W-1:0] addr, input logic wr, input logic [2:0] size,
      input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata, output logic [1:0] resp,
      output logic sel_seen);
    int cycles;
    rdata    = '0;
    resp     = 2'b00;
    sel_seen = 1'b0;
    cycles   = 0;
    if (timed_out) begin
      return;
    end
    @(posedge i_hclk);
    i_hsel   <= 1'b1;
    i_htrans <= ($urandom % 2) ? HTRANS_SEQ : HTRANS_NONSEQ;
    i_haddr  <= addr;
    i_hwrite <= wr;
    i_hsize  <= size;
    i_hprot  <= 4'($urandom);
    @(posedge i_hclk);
    i_hsel   <= 1'($urandom);
    i_htrans <= ($urandom % 2) ? HTRANS_BUSY : HTRANS_IDLE;
    i_hwdata <= wdata;
    do begin
      @(negedge i_hclk);
      cycles++;
      sel_seen = sel_seen | (|o_psel);
      if (o_hresp == HRESP_ERROR && !o_hreadyout) begin
        resp[1] = 1'b1;
      end
    end while (!o_hreadyout && cycles < TIMEOUT);
    if (!o_hreadyout) begin
      timed_out = 1'b1;
      $display("transfer to %h did not complete within %0d cycles", addr, TIMEOUT);
    end
    resp[0] = (o_hresp == HRESP_ERROR);
    rdata   = o_hrdata;
  endtask

  task automatic checked_access(input int slv, input int word, input logic wr,
      input logic [2:0] size);
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        resp;
    logic [1:0]        lo;
    logic              sel_seen;
    lo = 2'($urandom);
    if (size == HSIZE_HALF) begin
      lo[0] = 1'b0;
    end else if (size == HSIZE_WORD) begin
      lo = 2'b00;
    end
    addr  = (ADDR_W'(slv) << 12) | (ADDR_W'(word) << 2) | ADDR_W'(lo);
    wdata = $urandom;
    ahb_xfer(addr, wr, size, wdata, rdata, resp, sel_seen);
    if (slv >= SLV_NUM || addr[11:0] == 12'hffc) begin
      assert (resp == 2'b11) else log_error($sformatf("no two-cycle error at %h", addr));
      assert (slv < SLV_NUM || !sel_seen)
        else log_error($sformatf("psel raised for unmapped %h", addr));
    end else begin
      assert (resp == 2'b00) else log_error($sformatf("unexpected error at %h", addr));
      if (wr) begin
        ref_mem[slv][word] = merge_lanes(ref_mem[slv][word], wdata, size, lo);
      end else begin
        assert (rdata == ref_mem[slv][word])
          else log_error($sformatf("read %h: expected %h, got %h", addr,
                                   ref_mem[slv][word], rdata));
      end
    end
  endtask

  task automatic start_test();
    base_errors = errors;
    base_chk    = apb1_top_i.apb1_chk_i.err_cnt;
  endtask

  task automatic end_test(input string name);
    int fails;
    fails = errors - base_errors + apb1_top_i.apb1_chk_i.err_cnt - base_chk;
    if (fails == 0) begin
      n_pass++;
      $display("test %s: passed", name);
    end else begin
      n_fail++;
      $display("test %s: failed with %0d errors", name, fails);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Test sequence.
  // ~~~~~~~~~~~~~~~~~~~~
  initial begin
    int slv;
    int cycles;
    int chk_errs;
    void'($urandom(32'h57a7_8a58));
    i_hsel     = 1'b0;
    i_hreadyin = 1'b1;
    i_haddr    = '0;
    i_hwrite   = 1'b0;
    i_htrans   = HTRANS_IDLE;
    i_hsize    = HSIZE_WORD;
    i_hprot    = '0;
    i_hwdata   = '0;
    for (int s = 0; s < SLV_NUM; s++) begin
      for (int w = 0; w < WORDS; w++) begin
        ref_mem[s][w] = fill_word(s, w);
      end
    end
    cycles = 0;
    while (i_rst_n !== 1'b1 && cycles < TIMEOUT) begin
      @(posedge i_hclk);
      cycles++;
    end
    if (i_rst_n !== 1'b1) begin
      timed_out = 1'b1;
      $display("reset was never released");
    end
    @(negedge i_hclk);

    start_test();
    assert (o_hreadyout && o_hresp == HRESP_OKAY && o_psel == '0 && !o_penable)
      else log_error("bus not idle after reset");
    end_test("reset state");

    start_test();
    repeat (20) begin
      slv    = $urandom % SLV_NUM;
      cycles = $urandom % (WORDS - 1);
      checked_access(slv, cycles, 1'b1, HSIZE_WORD);
      checked_access(slv, cycles, 1'b0, HSIZE_WORD);
    end
    end_test("word write and read");

    start_test();
    repeat (20) begin
      slv    = $urandom % SLV_NUM;
      cycles = $urandom % (WORDS - 1);
      checked_access(slv, cycles, 1'b1, ($urandom % 2) ? HSIZE_HALF : HSIZE_BYTE);
      checked_access(slv, cycles, 1'b0, HSIZE_WORD);
    end
    end_test("byte and halfword lanes");

    start_test();
    repeat (8) begin
      checked_access(SLV_NUM + $urandom % 4, $urandom % WORDS, 1'($urandom), HSIZE_WORD);
      checked_access($urandom % SLV_NUM, WORDS - 1, 1'($urandom), HSIZE_WORD);
    end
    end_test("error responses");

    start_test();
    repeat (60) begin
      cycles = (($urandom % 8) == 0) ? WORDS - 1 : $urandom % (WORDS - 1);
      checked_access($urandom % SLV_NUM, cycles, 1'($urandom), 3'($urandom % 3));
    end
    end_test("random traffic");

    chk_errs = apb1_top_i.apb1_chk_i.err_cnt;
    $display("tests: %0d passed, %0d failed, %0d check errors, %0d assertion failures",
             n_pass, n_fail, errors, chk_errs);
    if (n_fail == 0 && errors == 0 && chk_errs == 0 && !timed_out) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
